// File: Bender.yml
package:
  name: usb_packet_bridge

sources:
  - common/usb_bridge_pkg.sv
  - common/packet_info_if.sv
  - rtl/ft_port/ft_read_engine.sv
  - rtl/ft_port/ft_write_engine.sv
  - rtl/packet/packet_receiver.sv
  - rtl/packet/reply_sender.sv
  - rtl/cmd_ram.sv
  - rtl/usb_packet_bridge.sv
  - target: test
    files:
      - verification/ft_host_model.sv
      - verification/tb_usb_packet_bridge.sv

// File: common/packet_info_if.sv
// Summary of a finished packet, receiver to reply sender
// Fields hold from done until the next header is found

interface packet_info_if;
	import usb_bridge_pkg::*;

	// One-cycle end of packet pulse
	logic  done;
	// Length field as received, low byte first
	word_t length;
	word_t service;
	// Set for bad length or bad trailer
	logic  error;

	modport receiver (
		output done,
		output length,
		output service,
		output error
	);

	modport sender (
		input done,
		input length,
		input service,
		input error
	);

endinterface

// File: common/usb_bridge_pkg.sv
// Shared types and constants of the USB packet bridge
// Timing marks are clk counts for an FT245R-class part and fit a 5-bit counter

package usb_bridge_pkg;

	// ========================================
	// Data widths
	// ========================================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [9:0]  ram_addr_t;

	// Packet store depth in 16-bit words
	localparam int ram_words = 1024;

	// ========================================
	// Packet framing symbols
	// ========================================
	localparam byte_t header_symbol  = 8'h55;
	localparam int    header_count   = 12;
	localparam byte_t trailer_symbol = 8'hAA;
	localparam int    trailer_count  = 8;
	localparam byte_t error_symbol   = 8'hEE;

	// Length counts itself, service type and trailer
	localparam word_t min_length       = 16'd12;
	localparam word_t loopback_service = 16'hCCCC;

	// ========================================
	// FIFO strobe timing
	// ========================================
	localparam logic [4:0] rd_strobe_start = 5'd2;
	localparam logic [4:0] rd_sample       = 5'd9;
	localparam logic [4:0] rd_strobe_stop  = 5'd12;
	localparam logic [4:0] rd_cycle_end    = 5'd25;

	localparam logic [4:0] wr_oe_start     = 5'd2;
	localparam logic [4:0] wr_strobe_start = 5'd5;
	localparam logic [4:0] wr_strobe_stop  = 5'd15;
	localparam logic [4:0] wr_oe_stop      = 5'd22;
	localparam logic [4:0] wr_cycle_end    = 5'd25;

	// Reply sections in send order
	typedef enum logic [2:0] {
		reply_idle,
		reply_header,
		reply_length,
		reply_service,
		reply_data,
		reply_trailer
	} reply_state_t;

endpackage

// File: rtl/cmd_ram.sv
// Packet data store, one write port and one read port
// Read data appears one clock after the address

module cmd_ram (
	input  logic                      clk,
	input  logic                      we,
	input  usb_bridge_pkg::ram_addr_t waddr,
	input  usb_bridge_pkg::word_t     wdata,
	input  usb_bridge_pkg::ram_addr_t raddr,
	output usb_bridge_pkg::word_t     rdata
);
	import usb_bridge_pkg::*;

	word_t mem [ram_words];

	// Write port from the receiver
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Registered read for the reply sender
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// File: rtl/ft_port/ft_read_engine.sv
// Timed FIFO read, one byte per falling edge of RXF#
// An edge seen while hold is high waits until hold drops

module ft_read_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ft_rxf_n,
	input  usb_bridge_pkg::byte_t ft_data_in,
	input  logic                  hold,
	output logic                  ft_rd_n,
	output usb_bridge_pkg::byte_t rx_byte,
	output logic                  rx_valid,
	output logic                  busy
);
	import usb_bridge_pkg::*;

	logic [1:0] rxf_sync;
	logic       rxf_last;
	logic       rxf_fall;
	logic       pending;
	logic       active;
	logic [4:0] count;

	// RXF# went low after the synchronizer
	assign rxf_fall = rxf_last && !rxf_sync[1];
	assign busy = active;

	always_ff @(posedge clk) begin
		if (reset) begin
			rxf_sync <= 2'b11;
			rxf_last <= 1'b1;
			pending  <= 1'b0;
			active   <= 1'b0;
			count    <= '0;
			ft_rd_n  <= 1'b1;
			rx_valid <= 1'b0;
		end else begin
			rxf_sync <= {rxf_sync[0], ft_rxf_n};
			rxf_last <= rxf_sync[1];
			// Byte is ready one cycle after the sample mark
			rx_valid <= active && (count == rd_sample);

			if (!active) begin
				if (pending && !hold) begin
					active  <= 1'b1;
					count   <= '0;
					pending <= 1'b0;
				end
			end else begin
				count <= count + 5'd1;
				if (count == rd_strobe_start)
					ft_rd_n <= 1'b0;
				if (count == rd_strobe_stop)
					ft_rd_n <= 1'b1;
				if (count == rd_cycle_end) begin
					active <= 1'b0;
					count  <= '0;
				end
			end

			// New edge wins over the start that consumes the old one
			if (rxf_fall)
				pending <= 1'b1;
		end
	end

	// Data latch at the sample mark
	always_ff @(posedge clk) begin
		if (active && (count == rd_sample))
			rx_byte <= ft_data_in;
	end

	// Receiver sees each byte once
	assert property (@(posedge clk) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

// File: rtl/ft_port/ft_write_engine.sv
// Timed FIFO write, one byte per accepted transfer
// A byte is only taken while the synchronized TXE# is low

module ft_write_engine (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ft_txe_n,
	input  usb_bridge_pkg::byte_t tx_byte,
	input  logic                  tx_valid,
	output logic                  tx_ready,
	output logic                  ft_wr,
	output usb_bridge_pkg::byte_t ft_data_out,
	output logic                  ft_data_oe,
	output logic                  busy
);
	import usb_bridge_pkg::*;

	logic [1:0] txe_sync;
	logic       active;
	logic [4:0] count;

	// No new byte during a write cycle or while the FIFO is full
	assign tx_ready = !active && !txe_sync[1];
	assign busy = active;

	always_ff @(posedge clk) begin
		if (reset) begin
			txe_sync   <= 2'b11;
			active     <= 1'b0;
			count      <= '0;
			ft_wr      <= 1'b0;
			ft_data_oe <= 1'b0;
		end else begin
			txe_sync <= {txe_sync[0], ft_txe_n};

			if (tx_valid && tx_ready) begin
				active <= 1'b1;
				count  <= '0;
			end else if (active) begin
				count <= count + 5'd1;
				// Bus driven around the strobe
				if (count == wr_oe_start)
					ft_data_oe <= 1'b1;
				if (count == wr_oe_stop)
					ft_data_oe <= 1'b0;
				if (count == wr_strobe_start)
					ft_wr <= 1'b1;
				if (count == wr_strobe_stop)
					ft_wr <= 1'b0;
				if (count == wr_cycle_end) begin
					active <= 1'b0;
					count  <= '0;
				end
			end
		end
	end

	// Output byte held for the whole cycle
	always_ff @(posedge clk) begin
		if (tx_valid && tx_ready)
			ft_data_out <= tx_byte;
	end

	// Strobe never outside the driven window
	assert property (@(posedge clk) disable iff (reset) ft_wr |-> ft_data_oe);

endmodule

// File: rtl/packet/packet_receiver.sv
// Header search, field capture and packet checks
// Data bytes are paired low byte first into 16-bit RAM words

module packet_receiver (
	input  logic                      clk,
	input  logic                      reset,
	input  usb_bridge_pkg::byte_t     rx_byte,
	input  logic                      rx_valid,
	output logic                      ram_we,
	output usb_bridge_pkg::ram_addr_t ram_waddr,
	output usb_bridge_pkg::word_t     ram_wdata,
	output logic                      active,
	packet_info_if.receiver           info
);
	import usb_bridge_pkg::*;

	logic [3:0] header_run;
	word_t      byte_cnt;
	byte_t      low_byte;
	logic       trailer_bad;
	word_t      length_next;
	word_t      data_index;
	word_t      trailer_start;
	logic       length_bad;
	logic       in_data;
	logic       in_trailer;
	logic       last_byte;

	// Full length as the high byte arrives
	assign length_next = {rx_byte, info.length[7:0]};
	// Too short, odd, or data larger than the RAM
	assign length_bad = (length_next < min_length) || length_next[0]
		|| ((length_next - min_length) > word_t'(2 * ram_words));

	// Byte positions after the service type
	assign data_index    = byte_cnt - 16'd4;
	assign trailer_start = info.length - word_t'(trailer_count);
	assign in_data       = (byte_cnt >= 16'd4) && (byte_cnt < trailer_start);
	assign in_trailer    = (byte_cnt >= 16'd4) && (byte_cnt >= trailer_start);
	assign last_byte     = (byte_cnt >= 16'd4) && (byte_cnt == info.length - 16'd1);

	// ========================================
	// Header search and packet control
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			active      <= 1'b0;
			header_run  <= '0;
			byte_cnt    <= '0;
			trailer_bad <= 1'b0;
			ram_we      <= 1'b0;
			info.done   <= 1'b0;
			info.error  <= 1'b0;
		end else begin
			info.done <= 1'b0;
			ram_we    <= 1'b0;
			if (rx_valid && !active) begin
				// Any other byte breaks the run
				if (rx_byte != header_symbol) begin
					header_run <= '0;
				end else if (header_run == 4'(header_count - 1)) begin
					header_run  <= '0;
					active      <= 1'b1;
					byte_cnt    <= '0;
					trailer_bad <= 1'b0;
					info.error  <= 1'b0;
				end else begin
					header_run <= header_run + 4'd1;
				end
			end else if (rx_valid) begin
				byte_cnt <= byte_cnt + 16'd1;
				if ((byte_cnt == 16'd1) && length_bad) begin
					// Abort right after the length field
					active     <= 1'b0;
					info.error <= 1'b1;
					info.done  <= 1'b1;
				end else if (last_byte) begin
					active     <= 1'b0;
					info.error <= trailer_bad || (rx_byte != trailer_symbol);
					info.done  <= 1'b1;
				end else begin
					if (in_data && data_index[0])
						ram_we <= 1'b1;
					if (in_trailer && (rx_byte != trailer_symbol))
						trailer_bad <= 1'b1;
				end
			end
		end
	end

	// ========================================
	// Field and data capture
	// ========================================
	always_ff @(posedge clk) begin
		if (rx_valid && active) begin
			case (byte_cnt)
				16'd0: info.length[7:0] <= rx_byte;
				16'd1: info.length[15:8] <= rx_byte;
				16'd2: info.service[7:0] <= rx_byte;
				16'd3: info.service[15:8] <= rx_byte;
				default: begin
					if (in_data && data_index[0]) begin
						ram_wdata <= {rx_byte, low_byte};
						ram_waddr <= data_index[10:1];
					end else if (in_data) begin
						low_byte <= rx_byte;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/packet/reply_sender.sv
// Reply byte sequencer, one byte per write engine transfer
// Data section only for error-free packets with data, zeros unless loopback

module reply_sender (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      tx_ready,
	input  usb_bridge_pkg::word_t     ram_rdata,
	packet_info_if.sender             info,
	output usb_bridge_pkg::byte_t     tx_byte,
	output logic                      tx_valid,
	output usb_bridge_pkg::ram_addr_t ram_raddr,
	output logic                      busy
);
	import usb_bridge_pkg::*;

	reply_state_t state;
	word_t        cnt;
	word_t        last_index;
	word_t        data_count;
	logic         transfer;
	logic         section_end;
	logic         loopback;

	assign data_count  = info.length - min_length;
	assign loopback    = (info.service == loopback_service);
	assign tx_valid    = (state != reply_idle);
	assign busy        = (state != reply_idle);
	assign transfer    = tx_valid && tx_ready;
	assign section_end = (cnt == last_index);

	// Index of the last byte of each section
	always_comb begin
		case (state)
			reply_header:  last_index = word_t'(header_count - 1);
			reply_length:  last_index = 16'd1;
			reply_service: last_index = 16'd1;
			reply_data:    last_index = data_count - 16'd1;
			reply_trailer: last_index = word_t'(trailer_count - 1);
			default:       last_index = '0;
		endcase
	end

	// ========================================
	// Section sequencing
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= reply_idle;
			cnt       <= '0;
			ram_raddr <= '0;
		end else if (state == reply_idle) begin
			if (info.done) begin
				state     <= reply_header;
				cnt       <= '0;
				// Word 0 is read during the header
				ram_raddr <= '0;
			end
		end else if (transfer) begin
			// High byte sent, fetch the next word early
			if ((state == reply_data) && cnt[0])
				ram_raddr <= ram_raddr + 10'd1;
			if (!section_end) begin
				cnt <= cnt + 16'd1;
			end else begin
				cnt <= '0;
				case (state)
					reply_header:  state <= reply_length;
					reply_length:  state <= reply_service;
					reply_service: begin
						if (info.error || (data_count == 16'd0))
							state <= reply_trailer;
						else
							state <= reply_data;
					end
					reply_data:    state <= reply_trailer;
					default:       state <= reply_idle;
				endcase
			end
		end
	end

	// Outgoing byte per section
	always_comb begin
		case (state)
			reply_header:  tx_byte = header_symbol;
			reply_length:  tx_byte = cnt[0] ? info.length[15:8] : info.length[7:0];
			reply_service: begin
				if (info.error)
					tx_byte = error_symbol;
				else
					tx_byte = cnt[0] ? info.service[15:8] : info.service[7:0];
			end
			reply_data: begin
				if (loopback)
					tx_byte = cnt[0] ? ram_rdata[15:8] : ram_rdata[7:0];
				else
					tx_byte = 8'h00;
			end
			reply_trailer: tx_byte = trailer_symbol;
			default:       tx_byte = 8'h00;
		endcase
	end

endmodule

// File: rtl/usb_packet_bridge.sv
// FT245 FIFO to packet store bridge with loopback reply
// Reads are held while a reply is being sent

module usb_packet_bridge (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ft_rxf_n,
	input  logic                  ft_txe_n,
	input  usb_bridge_pkg::byte_t ft_data_in,
	output logic                  ft_rd_n,
	output logic                  ft_wr,
	output usb_bridge_pkg::byte_t ft_data_out,
	output logic                  ft_data_oe,
	output logic                  usb_active,
	output logic                  packet_active,
	output logic                  packet_error
);
	import usb_bridge_pkg::*;

	byte_t     rx_byte;
	logic      rx_valid;
	logic      rd_busy;
	byte_t     tx_byte;
	logic      tx_valid;
	logic      tx_ready;
	logic      wr_busy;
	logic      reply_busy;
	logic      ram_we;
	ram_addr_t ram_waddr;
	word_t     ram_wdata;
	ram_addr_t ram_raddr;
	word_t     ram_rdata;

	packet_info_if info_if ();

	// Receive path
	ft_read_engine u_read (
		.clk        (clk),
		.reset      (reset),
		.ft_rxf_n   (ft_rxf_n),
		.ft_data_in (ft_data_in),
		.hold       (reply_busy),
		.ft_rd_n    (ft_rd_n),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.busy       (rd_busy)
	);

	packet_receiver u_receiver (
		.clk       (clk),
		.reset     (reset),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.ram_we    (ram_we),
		.ram_waddr (ram_waddr),
		.ram_wdata (ram_wdata),
		.active    (packet_active),
		.info      (info_if.receiver)
	);

	cmd_ram u_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (ram_raddr),
		.rdata (ram_rdata)
	);

	// Reply path
	reply_sender u_sender (
		.clk       (clk),
		.reset     (reset),
		.tx_ready  (tx_ready),
		.ram_rdata (ram_rdata),
		.info      (info_if.sender),
		.tx_byte   (tx_byte),
		.tx_valid  (tx_valid),
		.ram_raddr (ram_raddr),
		.busy      (reply_busy)
	);

	ft_write_engine u_write (
		.clk         (clk),
		.reset       (reset),
		.ft_txe_n    (ft_txe_n),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready),
		.ft_wr       (ft_wr),
		.ft_data_out (ft_data_out),
		.ft_data_oe  (ft_data_oe),
		.busy        (wr_busy)
	);

	assign usb_active   = rd_busy | wr_busy;
	assign packet_error = info_if.error;

endmodule

// File: src.f
common/usb_bridge_pkg.sv
common/packet_info_if.sv
rtl/ft_port/ft_read_engine.sv
rtl/ft_port/ft_write_engine.sv
rtl/packet/packet_receiver.sv
rtl/packet/reply_sender.sv
rtl/cmd_ram.sv
rtl/usb_packet_bridge.sv
verification/ft_host_model.sv
verification/tb_usb_packet_bridge.sv

// File: verification/ft_host_model.sv
// Behavioral FT245-style FIFO chip for the bridge testbench
// Offers one byte per RXF# fall and latches written bytes on WR falling edge
// Keeps at most 512 written bytes

module ft_host_model (
	input  logic       clk,
	input  logic       ft_rd_n,
	input  logic       ft_wr,
	input  logic [7:0] ft_data_out,
	input  logic       ft_data_oe,
	output logic       ft_rxf_n,
	output logic       ft_txe_n,
	output logic [7:0] ft_data_in,
	output int         written_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// Longest wait for one read strobe edge, in clk cycles
	localparam int strobe_timeout = 2000;

	logic [7:0] written [512];

	// Nothing to read, room to write
	initial begin
		ft_rxf_n   = 1'b1;
		ft_txe_n   = 1'b0;
		ft_data_in = 8'h00;
	end

	// Bytes written by the bridge, in arrival order
	initial begin
		written_count = 0;
		forever begin
			@(negedge ft_wr);
			// Only a real strobe while the bus is driven
			if (ft_data_oe && (written_count < 512)) begin
				written[written_count] = ft_data_out;
				written_count = written_count + 1;
			end
		end
	end

	// One byte through a full RD# low pulse, ok low on timeout
	task automatic offer_byte(input logic [7:0] b, output logic ok);
		int cycles;
		ok = 1'b1;
		@(posedge clk);
		ft_data_in <= b;
		ft_rxf_n   <= 1'b0;
		cycles = 0;
		while (ft_rd_n && ok) begin
			@(negedge clk);
			cycles = cycles + 1;
			if (cycles > strobe_timeout)
				ok = 1'b0;
		end
		cycles = 0;
		while (!ft_rd_n && ok) begin
			@(negedge clk);
			cycles = cycles + 1;
			if (cycles > strobe_timeout)
				ok = 1'b0;
		end
		// Byte consumed, FIFO empty again
		@(posedge clk);
		ft_rxf_n <= 1'b1;
		@(posedge clk);
	endtask

	// FIFO full for a number of cycles
	task automatic hold_txe(input int cycles);
		@(posedge clk);
		ft_txe_n <= 1'b1;
		repeat (cycles) @(posedge clk);
		ft_txe_n <= 1'b0;
	endtask

	function automatic logic [7:0] written_byte(input int index);
		return written[index];
	endfunction

endmodule

// File: verification/tb_usb_packet_bridge.sv
// Testbench for the USB packet bridge with one packet and one reply per table row
// Expected replies follow the framing rules and data bytes come from a fixed LFSR seed
// Stops at the first mismatch or timeout

module tb_usb_packet_bridge;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int row_count = 7;
	localparam int max_bytes = 64;
	// Cycles without a new reply byte before giving up
	localparam int byte_timeout = 400;

	logic       clk;
	logic       reset;
	logic       ft_rxf_n;
	logic       ft_txe_n;
	logic [7:0] ft_data_in;
	logic       ft_rd_n;
	logic       ft_wr;
	logic [7:0] ft_data_out;
	logic       ft_data_oe;
	logic       usb_active;
	logic       packet_active;
	logic       packet_error;
	int         written_count;

	// ========================================
	// Stimulus table
	// ========================================
	logic [7:0] stim_bytes [row_count][max_bytes];
	int         stim_len [row_count];
	logic [7:0] expect_bytes [row_count][max_bytes];
	int         expect_len [row_count];
	logic       expect_error [row_count];
	// TXE# held high in mid reply
	logic       use_backpressure [row_count];

	logic [31:0] lfsr_state;
	int          error_count;
	// Receiver left header search during the current row
	logic        packet_seen;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(negedge clk) begin
		if (packet_active)
			packet_seen = 1'b1;
	end

	usb_packet_bridge dut0 (
		.clk           (clk),
		.reset         (reset),
		.ft_rxf_n      (ft_rxf_n),
		.ft_txe_n      (ft_txe_n),
		.ft_data_in    (ft_data_in),
		.ft_rd_n       (ft_rd_n),
		.ft_wr         (ft_wr),
		.ft_data_out   (ft_data_out),
		.ft_data_oe    (ft_data_oe),
		.usb_active    (usb_active),
		.packet_active (packet_active),
		.packet_error  (packet_error)
	);

	ft_host_model host0 (
		.clk           (clk),
		.ft_rd_n       (ft_rd_n),
		.ft_wr         (ft_wr),
		.ft_data_out   (ft_data_out),
		.ft_data_oe    (ft_data_oe),
		.ft_rxf_n      (ft_rxf_n),
		.ft_txe_n      (ft_txe_n),
		.ft_data_in    (ft_data_in),
		.written_count (written_count)
	);

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit with the low bit first
	task automatic random_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			b[k] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic report_failure(input string reason);
		error_count = error_count + 1;
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want)
			report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h",
				name, got, want));
	endtask

	task automatic add_stim(input int row, input logic [7:0] b);
		stim_bytes[row][stim_len[row]] = b;
		stim_len[row] = stim_len[row] + 1;
	endtask

	task automatic add_expect(input int row, input logic [7:0] b);
		expect_bytes[row][expect_len[row]] = b;
		expect_len[row] = expect_len[row] + 1;
	endtask

	// Full frame where bad_trailer >= 0 corrupts that trailer byte
	task automatic build_frame(input int row, input logic [15:0] length,
			input logic [15:0] service, input int bad_trailer);
		logic [7:0] data;
		logic       err;
		err = (bad_trailer >= 0);
		for (int i = 0; i < 12; i++) begin
			add_stim(row, 8'h55);
			add_expect(row, 8'h55);
		end
		add_stim(row, length[7:0]);
		add_stim(row, length[15:8]);
		add_expect(row, length[7:0]);
		add_expect(row, length[15:8]);
		add_stim(row, service[7:0]);
		add_stim(row, service[15:8]);
		add_expect(row, err ? 8'hEE : service[7:0]);
		add_expect(row, err ? 8'hEE : service[15:8]);
		// Data echoed only for loopback and dropped on error
		for (int i = 0; i < int'(length) - 12; i++) begin
			random_byte(data);
			add_stim(row, data);
			if (!err)
				add_expect(row, (service == 16'hCCCC) ? data : 8'h00);
		end
		for (int i = 0; i < 8; i++) begin
			add_stim(row, (i == bad_trailer) ? 8'hAB : 8'hAA);
			add_expect(row, 8'hAA);
		end
		expect_error[row] = err;
	endtask

	// Header and a rejected length with nothing after it
	task automatic build_bad_length(input int row, input logic [15:0] length);
		for (int i = 0; i < 12; i++) begin
			add_stim(row, 8'h55);
			add_expect(row, 8'h55);
		end
		add_stim(row, length[7:0]);
		add_stim(row, length[15:8]);
		add_expect(row, length[7:0]);
		add_expect(row, length[15:8]);
		add_expect(row, 8'hEE);
		add_expect(row, 8'hEE);
		for (int i = 0; i < 8; i++)
			add_expect(row, 8'hAA);
		expect_error[row] = 1'b1;
	endtask

	task automatic build_table();
		for (int r = 0; r < row_count; r++) begin
			stim_len[r] = 0;
			expect_len[r] = 0;
			use_backpressure[r] = 1'b0;
		end
		build_frame(0, 16'd20, 16'hCCCC, -1);
		build_frame(1, 16'd18, 16'h1234, -1);
		build_bad_length(2, 16'd10);
		build_bad_length(3, 16'd19);
		build_frame(4, 16'd16, 16'hCCCC, 5);
		// Noise and then a run of 11 header bytes broken by 0x54
		add_stim(5, 8'h12);
		add_stim(5, 8'h55);
		add_stim(5, 8'h00);
		for (int i = 0; i < 11; i++)
			add_stim(5, 8'h55);
		add_stim(5, 8'h54);
		build_frame(5, 16'd20, 16'hCCCC, -1);
		// Row 0 again with a full FIFO in mid reply
		stim_len[6] = stim_len[0];
		expect_len[6] = expect_len[0];
		expect_error[6] = expect_error[0];
		for (int i = 0; i < max_bytes; i++) begin
			stim_bytes[6][i] = stim_bytes[0][i];
			expect_bytes[6][i] = expect_bytes[0][i];
		end
		use_backpressure[6] = 1'b1;
	endtask

	// ========================================
	// Reply checks
	// ========================================
	task automatic check_backpressure(input int base);
		int wait_count;
		wait_count = 0;
		while (written_count - base < 3) begin
			@(negedge clk);
			wait_count = wait_count + 1;
			if (wait_count > 3 * byte_timeout)
				report_failure("reply did not start before the FIFO was made full");
		end
		fork
			host0.hold_txe(150);
			begin
				// Current write cycle runs out first
				wait_count = 0;
				while (ft_data_oe) begin
					@(negedge clk);
					wait_count = wait_count + 1;
					if (wait_count > 40)
						report_failure("write cycle did not end while the FIFO was full");
				end
				repeat (100) begin
					@(negedge clk);
					check_value("ft_wr", ft_wr, 1'b0);
				end
			end
		join
	endtask

	task automatic collect_reply(input int row, input int base);
		int idle;
		int seen;
		idle = 0;
		seen = written_count - base;
		while (written_count - base < expect_len[row]) begin
			@(negedge clk);
			if (written_count - base != seen) begin
				seen = written_count - base;
				idle = 0;
			end else begin
				idle = idle + 1;
				if (idle > byte_timeout)
					report_failure($sformatf("row %0d: reply stalled after %0d of %0d bytes",
						row, seen, expect_len[row]));
			end
		end
		idle = 0;
		while (usb_active) begin
			@(negedge clk);
			idle = idle + 1;
			if (idle > 100)
				report_failure("bridge stayed busy after the last reply byte");
		end
		// Quiet time long enough for one more byte to show up
		repeat (60) @(negedge clk);
		check_value("written_count", written_count - base, expect_len[row]);
		for (int i = 0; i < expect_len[row]; i++)
			check_value($sformatf("ft_data_out row %0d byte %0d", row, i),
				host0.written_byte(base + i), expect_bytes[row][i]);
		check_value("packet_error", packet_error, expect_error[row]);
		check_value("packet_active", packet_active, 1'b0);
		check_value("packet_active during packet", packet_seen, 1'b1);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int   base;
		logic ok;
		error_count = 0;
		packet_seen = 1'b0;
		lfsr_state = 32'hff9fe92e;
		reset = 1'b1;
		build_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// Idle outputs after reset
		check_value("ft_rd_n", ft_rd_n, 1'b1);
		check_value("ft_wr", ft_wr, 1'b0);
		check_value("ft_data_oe", ft_data_oe, 1'b0);
		check_value("usb_active", usb_active, 1'b0);
		check_value("packet_active", packet_active, 1'b0);
		check_value("packet_error", packet_error, 1'b0);
		for (int r = 0; r < row_count; r++) begin
			base = written_count;
			packet_seen = 1'b0;
			for (int i = 0; i < stim_len[r]; i++) begin
				host0.offer_byte(stim_bytes[r][i], ok);
				if (!ok)
					report_failure($sformatf("row %0d: no read strobe for byte %0d", r, i));
			end
			if (use_backpressure[r])
				check_backpressure(base);
			collect_reply(r, base);
		end
		if (error_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "errors found");
		end
	end

endmodule
